/* tb.f */
+incdir+hw
hw/side_ch_cfg_pkg.sv
hw/side_ch_data_pkg.sv
hw/iq_trigger_sel.sv
hw/iq_ring_buf.sv
hw/iq_capture_ctrl.sv
hw/dma_stream_sel.sv
hw/side_ch_iq_top.sv
verif/side_ch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the IQ snapshot testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module side_ch_tb -f tb.f -o sim_side_ch
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_side_ch > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
	exit 0
fi
exit 1

/* verif/side_ch_tb.sv */
// drives the IQ snapshot top through loopback, start pulses and snapshot frames
// receive strobes are random, tsf counts one per cycle
`default_nettype none
`include "side_ch_defs.svh"

module side_ch_tb
	import side_ch_cfg_pkg::*;
	import side_ch_data_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TARGET = 16;
	localparam int FRAME_LIMIT = 300; // cycles to wait for one frame
	localparam int RUN_CYCLES = 40 + 60 + 2 * FRAME_LIMIT + 2 * FRAME_LIMIT + 100
		+ FRAME_LIMIT + 200;

	logic clk, rstn, iq_capture, pack_iq1, free_run;
	src_sel_e src_sel;
	trig_sel_e trig_sel;
	start_mode_e start_mode;
	iq_pair_t rx_iq0, rx_iq1, mtx_iq0, mtx_iq1, itx_iq0, itx_iq1;
	logic rx_strobe, mtx_valid, itx_valid;
	logic signed [`SC_RSSI_W-1:0] rssi_half_db, rssi_th;
	logic [`SC_GPIO_W-1:0] gpio_status;
	logic [`SC_IQ_W-1:0] iq_th;
	logic fcs_in_strobe, fcs_ok, pkt_header_valid_strobe, pkt_header_valid;
	logic phy_tx_started, phy_tx_done, tx_bb_is_ongoing;
	tsf_t tsf_runtime_val;
	len_t pre_trigger_len, iq_len_target, m_axis_data_count;
	logic len_reg_wr, ext_start, s_tlast, emptyn_to_pl;
	dma_word_t data_to_pl, data_to_ps;
	logic data_to_ps_valid, m_axis_start_1trans, pl_ask_data;

	int errors = 0;
	int tests_failed = 0;
	int frame_words = 0;
	int frame_idx = 0;
	int frames_done = 0;
	int starts = 0;
	logic check_tsf = 1'b0;
	logic tsf_arm = 1'b0;
	tsf_t exp_tsf = '0;
	logic [15:0] last_i = '0;
	logic [15:0] i_cnt = '0;
	logic [31:0] rng = 32'h05b77a79;
	logic [31:0] rnd;
	logic wr_h1 = 1'b0;
	logic wr_h2 = 1'b0;

	side_ch_iq_top i_side_ch_iq_top (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic report_mismatch(input string sig, input logic [63:0] got,
			input logic [63:0] exp);
		$display("CHECK FAILED at %0t: %s got %h expected %h", $time, sig, got, exp);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("failure at %0t: %s", $time, what);
		errors++;
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#(RUN_CYCLES * 20);
		$display("timeout: the tests did not finish in %0d cycles", RUN_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	// sample source and timestamp
	always @(posedge clk) begin
		tsf_runtime_val <= tsf_runtime_val + 1'b1;
		rnd = xorshift(rng);
		rng = rnd;
		rx_strobe <= (rnd[1:0] != 2'b00);
		data_to_pl <= {rnd, ~rnd};
		emptyn_to_pl <= rnd[5];
		s_tlast <= rnd[9];
		if (rnd[1:0] != 2'b00) begin
			rx_iq0 <= {16'h0, i_cnt}; // I low, Q high
			i_cnt <= i_cnt + 1'b1;
		end
	end

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		if (rstn && start_mode == MODE_LOOP) begin
			assert (data_to_ps == data_to_pl)
				else report_mismatch("data_to_ps", data_to_ps, data_to_pl);
			assert (data_to_ps_valid == emptyn_to_pl)
				else report_mismatch("data_to_ps_valid", data_to_ps_valid, emptyn_to_pl);
			assert (m_axis_start_1trans == s_tlast)
				else report_mismatch("m_axis_start_1trans", m_axis_start_1trans, s_tlast);
			assert (pl_ask_data == 1'b1)
				else report_mismatch("pl_ask_data", pl_ask_data, 1);
		end
		if (rstn && start_mode == MODE_OFF) begin
			assert (data_to_ps == '0)
				else report_mismatch("data_to_ps", data_to_ps, 0);
			assert (data_to_ps_valid == 1'b0)
				else report_mismatch("data_to_ps_valid", data_to_ps_valid, 0);
			assert (m_axis_start_1trans == 1'b0)
				else report_mismatch("m_axis_start_1trans", m_axis_start_1trans, 0);
			assert (pl_ask_data == 1'b0)
				else report_mismatch("pl_ask_data", pl_ask_data, 0);
		end
		if (rstn && (start_mode == MODE_AUTO || start_mode == MODE_EXT)) begin
			assert (pl_ask_data == 1'b0)
				else report_mismatch("pl_ask_data", pl_ask_data, 0);
		end
		if (rstn && start_mode == MODE_AUTO) begin
			// pulse two edges after the write rises
			assert (m_axis_start_1trans == (wr_h1 & ~wr_h2))
				else report_mismatch("m_axis_start_1trans", m_axis_start_1trans,
					wr_h1 & ~wr_h2);
		end
		if (rstn && start_mode == MODE_EXT) begin
			assert (m_axis_start_1trans == ext_start)
				else report_mismatch("m_axis_start_1trans", m_axis_start_1trans, ext_start);
		end
		if (m_axis_start_1trans && start_mode != MODE_LOOP)
			starts++;
		wr_h2 = rstn ? wr_h1 : 1'b0;
		wr_h1 = rstn ? len_reg_wr : 1'b0;

		if (tsf_arm) begin
			exp_tsf = tsf_runtime_val;
			tsf_arm = 1'b0;
		end
		if (fcs_in_strobe && fcs_ok && trig_sel == TRIG_FCS_OK)
			tsf_arm = 1'b1;

		if (rstn && start_mode != MODE_LOOP && data_to_ps_valid) begin
			if (frame_idx == 0) begin
				if (check_tsf)
					assert (data_to_ps == exp_tsf)
						else report_mismatch("data_to_ps header", data_to_ps, exp_tsf);
			end else begin
				if (frame_idx > 1)
					assert (data_to_ps[15:0] == last_i + 1'b1)
						else report_mismatch("data_to_ps I", data_to_ps[15:0], last_i + 1'b1);
				last_i = data_to_ps[15:0];
				if (!pack_iq1) begin
					assert (data_to_ps[63:32] == {5'b0, rssi_half_db, 8'b0, gpio_status})
						else report_mismatch("data_to_ps status", data_to_ps[63:32],
							{5'b0, rssi_half_db, 8'b0, gpio_status});
				end
			end
			frame_words++;
			if (frame_idx == TARGET) begin
				frame_idx = 0;
				frames_done++;
			end else begin
				frame_idx++;
			end
		end
	end

	task automatic cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic pulse_fcs(input logic ok);
		@(posedge clk);
		fcs_ok <= ok;
		fcs_in_strobe <= 1'b1;
		@(posedge clk);
		fcs_in_strobe <= 1'b0;
	endtask

	// waits for one complete frame, then checks its length
	task automatic expect_frame(input int words_before, input int frames_before);
		int n;
		n = 0;
		while (frames_done == frames_before && n < FRAME_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (frames_done == frames_before)
			report_problem("no complete frame appeared");
		cycles(20);
		assert (frame_words - words_before == TARGET + 1)
			else report_mismatch("frame word count", frame_words - words_before, TARGET + 1);
	endtask

	task automatic expect_no_frame(input int words_before);
		cycles(60);
		assert (frame_words == words_before)
			else report_problem("a frame was sent although none was due");
	endtask

	task automatic end_test(input string name, input int errs_before);
		$display("test %-20s %s", name, (errors == errs_before) ? "pass" : "fail");
		if (errors != errs_before)
			tests_failed++;
	endtask

	initial begin
		int e;
		int w;
		int f;
		rstn = 1'b0;
		iq_capture = 1'b0;
		src_sel = SRC_RX;
		pack_iq1 = 1'b1;
		trig_sel = TRIG_FCS_OK;
		free_run = 1'b0;
		start_mode = MODE_LOOP;
		rx_iq0 = '0;
		rx_iq1 = 32'h1234_0000;
		{mtx_iq0, mtx_iq1, itx_iq0, itx_iq1} = '0;
		{rx_strobe, mtx_valid, itx_valid} = '0;
		rssi_half_db = 11'sd50;
		rssi_th = 11'sd100;
		gpio_status = 8'h00;
		iq_th = 16'h7fff;
		{fcs_in_strobe, fcs_ok, pkt_header_valid_strobe, pkt_header_valid} = '0;
		{phy_tx_started, phy_tx_done, tx_bb_is_ongoing} = '0;
		tsf_runtime_val = 64'h0000_0100_0000_0000;
		pre_trigger_len = 14'd4;
		iq_len_target = 14'(TARGET);
		m_axis_data_count = '0;
		{len_reg_wr, ext_start, s_tlast, emptyn_to_pl} = '0;
		data_to_pl = '0;
		cycles(5);
		rstn <= 1'b1;
		iq_capture <= 1'b1;

		e = errors;
		cycles(30);
		start_mode <= MODE_OFF;
		cycles(10);
		end_test("loopback and off", e);

		e = errors;
		start_mode <= MODE_AUTO;
		cycles(5);
		starts = 0;
		len_reg_wr <= 1'b1;
		cycles(3);
		len_reg_wr <= 1'b0;
		cycles(8);
		assert (starts == 1) else report_mismatch("auto start pulses", starts, 1);
		start_mode <= MODE_EXT;
		cycles(2);
		ext_start <= 1'b1;
		cycles(1);
		ext_start <= 1'b0;
		cycles(5);
		end_test("start pulses", e);

		e = errors;
		start_mode <= MODE_AUTO;
		check_tsf <= 1'b1;
		w = frame_words;
		f = frames_done;
		pulse_fcs(1'b1);
		expect_frame(w, f);
		w = frame_words;
		pulse_fcs(1'b0);
		expect_no_frame(w);
		check_tsf <= 1'b0;
		end_test("fcs ok snapshot", e);

		e = errors;
		trig_sel <= TRIG_RSSI_RISE;
		cycles(10);
		w = frame_words;
		f = frames_done;
		rssi_half_db <= 11'sd150;
		expect_frame(w, f);
		rssi_half_db <= 11'sd50;
		cycles(10);
		trig_sel <= TRIG_RSSI_FALL;
		cycles(5);
		w = frame_words;
		rssi_half_db <= 11'sd150;
		expect_no_frame(w);
		end_test("rssi trigger", e);

		e = errors;
		trig_sel <= TRIG_FCS;
		m_axis_data_count <= 14'(`SC_DMA_CAP - TARGET); // one word short
		cycles(5);
		w = frame_words;
		pulse_fcs(1'b1);
		expect_no_frame(w);
		m_axis_data_count <= '0;
		end_test("back-pressure", e);

		e = errors;
		pack_iq1 <= 1'b0;
		rssi_half_db <= 11'sd300;
		gpio_status <= 8'h5a;
		cycles(20); // pre-trigger words carry the new status
		w = frame_words;
		f = frames_done;
		pulse_fcs(1'b1);
		expect_frame(w, f);
		end_test("status packing", e);

		$display("tests 6, tests failed %0d, checks failed %0d", tests_failed, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hw/side_ch_iq_top.sv */
// IQ snapshot side channel top, iq_capture enables buffer, trigger and FSM
`default_nettype none
`include "side_ch_defs.svh"

module side_ch_iq_top
	import side_ch_cfg_pkg::*;
	import side_ch_data_pkg::*;
(
	input wire clk,
	input wire rstn,
	input wire iq_capture,
	input wire src_sel_e src_sel,
	input wire pack_iq1,
	input wire trig_sel_e trig_sel,
	input wire free_run,
	input wire start_mode_e start_mode,
	input wire iq_pair_t rx_iq0,
	input wire iq_pair_t rx_iq1,
	input wire rx_strobe,
	input wire iq_pair_t mtx_iq0,
	input wire iq_pair_t mtx_iq1,
	input wire mtx_valid,
	input wire iq_pair_t itx_iq0,
	input wire iq_pair_t itx_iq1,
	input wire itx_valid,
	input wire logic signed [`SC_RSSI_W-1:0] rssi_half_db,
	input wire logic signed [`SC_RSSI_W-1:0] rssi_th,
	input wire logic [`SC_GPIO_W-1:0] gpio_status,
	input wire logic [`SC_IQ_W-1:0] iq_th,
	input wire fcs_in_strobe,
	input wire fcs_ok,
	input wire pkt_header_valid_strobe,
	input wire pkt_header_valid,
	input wire phy_tx_started,
	input wire phy_tx_done,
	input wire tx_bb_is_ongoing,
	input wire tsf_t tsf_runtime_val,
	input wire len_t pre_trigger_len,
	input wire len_t iq_len_target,
	input wire len_t m_axis_data_count,
	input wire len_reg_wr,
	input wire ext_start,
	input wire s_tlast,
	input wire dma_word_t data_to_pl,
	input wire emptyn_to_pl,
	output dma_word_t data_to_ps,
	output logic data_to_ps_valid,
	output logic m_axis_start_1trans,
	output logic pl_ask_data
);

	buf_addr_t wptr;
	buf_addr_t raddr;
	logic sample_strobe;
	dma_word_t rdata;
	logic trig;
	dma_word_t cap_data;
	logic cap_valid;

	iq_ring_buf i_buf (
		.clk(clk), .rstn(rstn), .capture_en(iq_capture), .src_sel(src_sel),
		.pack_iq1(pack_iq1), .rx_iq0(rx_iq0), .rx_iq1(rx_iq1),
		.mtx_iq0(mtx_iq0), .mtx_iq1(mtx_iq1), .itx_iq0(itx_iq0), .itx_iq1(itx_iq1),
		.rx_strobe(rx_strobe), .mtx_valid(mtx_valid), .itx_valid(itx_valid),
		.rssi_half_db(rssi_half_db), .gpio_status(gpio_status), .raddr(raddr),
		.wptr(wptr), .sample_strobe(sample_strobe), .rdata(rdata)
	);

	// amplitude trigger looks at the receive iq1
	iq_trigger_sel i_trig (
		.clk(clk), .rstn(rstn), .capture_en(iq_capture), .trig_sel(trig_sel),
		.free_run(free_run), .fcs_in_strobe(fcs_in_strobe), .fcs_ok(fcs_ok),
		.pkt_header_valid_strobe(pkt_header_valid_strobe),
		.pkt_header_valid(pkt_header_valid), .rssi_half_db(rssi_half_db),
		.rssi_th(rssi_th), .gpio_status(gpio_status), .phy_tx_started(phy_tx_started),
		.phy_tx_done(phy_tx_done), .tx_bb_is_ongoing(tx_bb_is_ongoing),
		.iq1(rx_iq1), .iq_th(iq_th), .trig(trig)
	);

	iq_capture_ctrl i_ctrl (
		.clk(clk), .rstn(rstn), .capture_en(iq_capture), .trig(trig),
		.tsf_runtime_val(tsf_runtime_val), .wptr(wptr), .sample_strobe(sample_strobe),
		.rdata(rdata), .pre_trigger_len(pre_trigger_len), .iq_len_target(iq_len_target),
		.m_axis_data_count(m_axis_data_count), .raddr(raddr), .cap_data(cap_data),
		.cap_valid(cap_valid)
	);

	dma_stream_sel i_sel (
		.clk(clk), .rstn(rstn), .start_mode(start_mode), .len_reg_wr(len_reg_wr),
		.ext_start(ext_start), .s_tlast(s_tlast), .data_to_pl(data_to_pl),
		.emptyn_to_pl(emptyn_to_pl), .cap_data(cap_data), .cap_valid(cap_valid),
		.data_to_ps(data_to_ps), .data_to_ps_valid(data_to_ps_valid),
		.m_axis_start_1trans(m_axis_start_1trans), .pl_ask_data(pl_ask_data)
	);

endmodule

`default_nettype wire

/* hw/dma_stream_sel.sv */
// DMA output select by start mode, off mode drives everything low
`default_nettype none

module dma_stream_sel
	import side_ch_cfg_pkg::*;
	import side_ch_data_pkg::*;
(
	input wire clk,
	input wire rstn,
	input wire start_mode_e start_mode,
	input wire len_reg_wr,
	input wire ext_start,
	input wire s_tlast,
	input wire dma_word_t data_to_pl,
	input wire emptyn_to_pl,
	input wire dma_word_t cap_data,
	input wire cap_valid,
	output dma_word_t data_to_ps,
	output logic data_to_ps_valid,
	output logic m_axis_start_1trans,
	output logic pl_ask_data
);

	logic wr_q1;
	logic wr_q2;
	logic auto_start;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_q1 <= 1'b0;
			wr_q2 <= 1'b0;
		end else begin
			wr_q1 <= len_reg_wr;
			wr_q2 <= wr_q1;
		end
	end

	assign auto_start = wr_q1 & ~wr_q2; // length write rising edge

	always_comb begin
		case (start_mode)
			MODE_LOOP: begin // slave stream straight back out
				data_to_ps = data_to_pl;
				data_to_ps_valid = emptyn_to_pl;
				m_axis_start_1trans = s_tlast;
				pl_ask_data = 1'b1;
			end
			MODE_AUTO: begin
				data_to_ps = cap_data;
				data_to_ps_valid = cap_valid;
				m_axis_start_1trans = auto_start;
				pl_ask_data = 1'b0;
			end
			MODE_EXT: begin
				data_to_ps = cap_data;
				data_to_ps_valid = cap_valid;
				m_axis_start_1trans = ext_start;
				pl_ask_data = 1'b0;
			end
			default: begin
				data_to_ps = '0;
				data_to_ps_valid = 1'b0;
				m_axis_start_1trans = 1'b0;
				pl_ask_data = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/iq_capture_ctrl.sv */
// one snapshot frame per accepted trigger: tsf header then iq_len_target words
// frame is dropped when the DMA FIFO lacks room, triggers outside wait are ignored
`default_nettype none
`include "side_ch_defs.svh"

module iq_capture_ctrl
	import side_ch_cfg_pkg::*;
	import side_ch_data_pkg::*;
(
	input wire clk,
	input wire rstn,
	input wire capture_en,
	input wire trig,
	input wire tsf_t tsf_runtime_val,
	input wire buf_addr_t wptr,
	input wire sample_strobe,
	input wire dma_word_t rdata,
	input wire len_t pre_trigger_len,
	input wire len_t iq_len_target,
	input wire len_t m_axis_data_count,
	output buf_addr_t raddr,
	output dma_word_t cap_data,
	output logic cap_valid
);

	cap_state_e state;
	len_t count;     // reads issued in this frame
	tsf_t tsf_lock;
	logic rd_pend;   // read issued on the last edge
	logic room_ok;
	logic issue;

	// header word plus all samples must fit
	assign room_ok = (int'(`SC_DMA_CAP) - int'(m_axis_data_count)) >=
		(int'(iq_len_target) + 1);
	assign issue = (state == CAP_SAMP) && sample_strobe && (count != iq_len_target);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= CAP_WAIT;
			count <= '0;
			raddr <= '0;
			rd_pend <= 1'b0;
			cap_valid <= 1'b0;
		end else if (!capture_en) begin
			state <= CAP_WAIT;
			rd_pend <= 1'b0;
			cap_valid <= 1'b0;
		end else begin
			rd_pend <= issue;
			case (state)
				CAP_WAIT: begin
					cap_valid <= 1'b0;
					count <= '0;
					if (trig) begin
						raddr <= wptr - buf_addr_t'(pre_trigger_len);
						state <= CAP_PREP;
					end
				end
				CAP_PREP: begin
					cap_valid <= 1'b0;
					state <= room_ok ? CAP_HDR : CAP_WAIT;
				end
				CAP_HDR: begin
					cap_valid <= 1'b1; // tsf word
					state <= CAP_SAMP;
				end
				CAP_SAMP: begin
					cap_valid <= rd_pend;
					if (issue) begin
						raddr <= raddr + 1'b1;
						count <= count + 1'b1;
					end
					// last pending word still goes out on this edge
					if (count == iq_len_target)
						state <= CAP_WAIT;
				end
				default: state <= CAP_WAIT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == CAP_WAIT && trig)
			tsf_lock <= tsf_runtime_val;
		if (state == CAP_HDR)
			cap_data <= tsf_lock;
		else if (rd_pend)
			cap_data <= rdata;
	end

	a_valid_state: assert property (@(posedge clk) disable iff (!rstn)
		cap_valid |-> $past(state) inside {CAP_HDR, CAP_SAMP});

	a_count_bound: assert property (@(posedge clk) disable iff (!rstn)
		state == CAP_SAMP |-> count <= iq_len_target);

endmodule

`default_nettype wire

/* hw/iq_ring_buf.sv */
// circular sample memory, one word per selected strobe while capture is on
// read data has one cycle of latency
`default_nettype none
`include "side_ch_defs.svh"

module iq_ring_buf
	import side_ch_cfg_pkg::*;
	import side_ch_data_pkg::*;
(
	input wire clk,
	input wire rstn,
	input wire capture_en,
	input wire src_sel_e src_sel,
	input wire pack_iq1,
	input wire iq_pair_t rx_iq0,
	input wire iq_pair_t rx_iq1,
	input wire iq_pair_t mtx_iq0,
	input wire iq_pair_t mtx_iq1,
	input wire iq_pair_t itx_iq0,
	input wire iq_pair_t itx_iq1,
	input wire rx_strobe,
	input wire mtx_valid,
	input wire itx_valid,
	input wire logic signed [`SC_RSSI_W-1:0] rssi_half_db,
	input wire logic [`SC_GPIO_W-1:0] gpio_status,
	input wire buf_addr_t raddr,
	output buf_addr_t wptr,
	output logic sample_strobe,
	output dma_word_t rdata
);

	iq_pair_t sel_iq0;
	iq_pair_t sel_iq1;
	dma_word_t wdata;
	dma_word_t mem [0:(1 << `SC_BUF_AW) - 1];

	always_comb begin
		case (src_sel)
			SRC_RX: begin
				sel_iq0 = rx_iq0;
				sel_iq1 = rx_iq1;
				sample_strobe = rx_strobe;
			end
			SRC_MTX: begin
				sel_iq0 = mtx_iq0;
				sel_iq1 = mtx_iq1;
				sample_strobe = mtx_valid;
			end
			default: begin // both upper codes pick the tx interface
				sel_iq0 = itx_iq0;
				sel_iq1 = itx_iq1;
				sample_strobe = itx_valid;
			end
		endcase
	end

	// status layout: rssi and gpio zero-filled to 16 bits each
	assign wdata = pack_iq1 ? {sel_iq1, sel_iq0} :
		{{(`SC_IQ_W - `SC_RSSI_W){1'b0}}, rssi_half_db,
		 {(`SC_IQ_W - `SC_GPIO_W){1'b0}}, gpio_status, sel_iq0};

	always_ff @(posedge clk) begin
		if (!rstn)
			wptr <= '0;
		else if (capture_en && sample_strobe)
			wptr <= wptr + 1'b1; // wraps, oldest word overwritten
	end

	always_ff @(posedge clk) begin
		if (capture_en && sample_strobe)
			mem[wptr] <= wdata;
		rdata <= mem[raddr];
	end

	a_no_wr_idle: assert property (@(posedge clk) disable iff (!rstn)
		!capture_en |=> $stable(wptr));

endmodule

`default_nettype wire

/* hw/iq_trigger_sel.sv */
// edge events appear two cycles after the input change, strobes one cycle
// trig stays low while capture_en is low
`default_nettype none
`include "side_ch_defs.svh"

module iq_trigger_sel
	import side_ch_cfg_pkg::*;
	import side_ch_data_pkg::*;
(
	input wire clk,
	input wire rstn,
	input wire capture_en,
	input wire trig_sel_e trig_sel,
	input wire free_run,
	input wire fcs_in_strobe,
	input wire fcs_ok,
	input wire pkt_header_valid_strobe,
	input wire pkt_header_valid,
	input wire logic signed [`SC_RSSI_W-1:0] rssi_half_db,
	input wire logic signed [`SC_RSSI_W-1:0] rssi_th,
	input wire logic [`SC_GPIO_W-1:0] gpio_status,
	input wire phy_tx_started,
	input wire phy_tx_done,
	input wire tx_bb_is_ongoing,
	input wire iq_pair_t iq1,
	input wire logic [`SC_IQ_W-1:0] iq_th,
	output logic trig
);

	logic signed [`SC_RSSI_W-1:0] rssi_q;
	logic agc_q;        // agc lock bit, gpio msb
	logic tx_bb_q;
	logic rssi_rise;
	logic rssi_fall;
	logic agc_unlock;
	logic agc_lock;
	logic [`SC_IQ_W-1:0] iq1_i;
	logic [`SC_IQ_W-1:0] iq1_i_abs;
	logic evt;

	assign iq1_i = iq1[`SC_IQ_W-1:0];
	assign iq1_i_abs = iq1_i[`SC_IQ_W-1] ? (~iq1_i + 1'b1) : iq1_i;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			rssi_q <= '0;
			agc_q <= 1'b0;
			tx_bb_q <= 1'b0;
			rssi_rise <= 1'b0;
			rssi_fall <= 1'b0;
			agc_unlock <= 1'b0;
			agc_lock <= 1'b0;
			trig <= 1'b0;
		end else begin
			rssi_q <= rssi_half_db;
			agc_q <= gpio_status[`SC_GPIO_W-1];
			tx_bb_q <= tx_bb_is_ongoing;
			rssi_rise <= (rssi_q < rssi_th) && (rssi_half_db >= rssi_th);
			rssi_fall <= (rssi_q >= rssi_th) && (rssi_half_db < rssi_th);
			agc_unlock <= agc_q && !gpio_status[`SC_GPIO_W-1];
			agc_lock <= !agc_q && gpio_status[`SC_GPIO_W-1];
			trig <= capture_en && evt;
		end
	end

	always_comb begin
		case (trig_sel)
			TRIG_FCS:        evt = fcs_in_strobe | free_run;
			TRIG_FCS_OK:     evt = fcs_in_strobe & fcs_ok;
			TRIG_FCS_BAD:    evt = fcs_in_strobe & ~fcs_ok;
			TRIG_HDR:        evt = pkt_header_valid_strobe;
			TRIG_HDR_OK:     evt = pkt_header_valid_strobe & pkt_header_valid;
			TRIG_HDR_BAD:    evt = pkt_header_valid_strobe & ~pkt_header_valid;
			TRIG_RSSI_RISE:  evt = rssi_rise;
			TRIG_RSSI_FALL:  evt = rssi_fall;
			TRIG_AGC_UNLOCK: evt = agc_unlock;
			TRIG_AGC_LOCK:   evt = agc_lock;
			TRIG_TX_START:   evt = phy_tx_started;
			TRIG_TX_DONE:    evt = phy_tx_done;
			TRIG_TX_AMP:     evt = tx_bb_q && (iq1_i_abs > iq_th); // own tx leaking into rx
			default:         evt = fcs_in_strobe;
		endcase
	end

	a_sel_known: assert property (@(posedge clk) disable iff (!rstn)
		!$isunknown(trig_sel));

endmodule

`default_nettype wire

/* hw/side_ch_data_pkg.sv */
// data word types, widths come from side_ch_defs.svh
`default_nettype none
`include "side_ch_defs.svh"

package side_ch_data_pkg;

	// I in the low half, Q in the high half
	typedef logic [2*`SC_IQ_W-1:0] iq_pair_t;

	typedef logic [`SC_DMA_W-1:0] dma_word_t;

	typedef logic [`SC_BUF_AW-1:0] buf_addr_t;

	typedef logic [`SC_LEN_W-1:0] len_t;

	typedef logic [`SC_TSF_W-1:0] tsf_t;

endpackage

`default_nettype wire

/* hw/side_ch_cfg_pkg.sv */
// configuration codes and controller states of the IQ snapshot
`default_nettype none

package side_ch_cfg_pkg;

	typedef enum logic [3:0] {
		TRIG_FCS        = 4'd0, // also free run
		TRIG_FCS_OK     = 4'd1,
		TRIG_FCS_BAD    = 4'd2,
		TRIG_HDR        = 4'd3,
		TRIG_HDR_OK     = 4'd4,
		TRIG_HDR_BAD    = 4'd5,
		TRIG_RSSI_RISE  = 4'd6,
		TRIG_RSSI_FALL  = 4'd7,
		TRIG_AGC_UNLOCK = 4'd8, // lock to unlock
		TRIG_AGC_LOCK   = 4'd9, // unlock to lock
		TRIG_TX_START   = 4'd10,
		TRIG_TX_DONE    = 4'd11,
		TRIG_TX_AMP     = 4'd12
	} trig_sel_e;

	typedef enum logic [1:0] {
		SRC_RX      = 2'd0,
		SRC_MTX     = 2'd1, // modem transmit
		SRC_ITX     = 2'd2, // transmit interface
		SRC_ITX_ALT = 2'd3
	} src_sel_e;

	typedef enum logic [1:0] {
		MODE_LOOP = 2'd0,
		MODE_AUTO = 2'd1,
		MODE_EXT  = 2'd2,
		MODE_OFF  = 2'd3
	} start_mode_e;

	typedef enum logic [1:0] {
		CAP_WAIT = 2'd0,
		CAP_PREP = 2'd1,
		CAP_HDR  = 2'd2,
		CAP_SAMP = 2'd3
	} cap_state_e;

endpackage

`default_nettype wire

/* hw/side_ch_defs.svh */
// widths and sizes of the IQ snapshot path
// SC_DMA_CAP must stay below the real DMA FIFO depth
`ifndef SIDE_CH_DEFS_SVH
`define SIDE_CH_DEFS_SVH

// one I or Q part
`define SC_IQ_W    16
`define SC_TSF_W   64
`define SC_DMA_W   64

// 1024 word ring buffer
`define SC_BUF_AW  10

`define SC_GPIO_W  8
`define SC_RSSI_W  11

// usable DMA FIFO words
`define SC_DMA_CAP 1000
`define SC_LEN_W   14

`endif
